// File: source/isa_pkg.sv
package isa_pkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0] reg_addr_t; // General registers carry a leading 0

	localparam reg_addr_t REG_SP = 4'h8;
	localparam reg_addr_t REG_T = 4'h9;
	localparam reg_addr_t REG_IH = 4'ha;
	localparam reg_addr_t REG_RA = 4'hb;
	localparam reg_addr_t REG_NONE = 4'hf; // No register

	////////////////////////////////////////////////////////////
	// Major opcodes, bits 15:11
	////////////////////////////////////////////////////////////
	localparam logic [4:0] OPC_NOP = 5'b00001;
	localparam logic [4:0] OPC_B = 5'b00010;
	localparam logic [4:0] OPC_BEQZ = 5'b00100;
	localparam logic [4:0] OPC_BNEZ = 5'b00101;
	localparam logic [4:0] OPC_SHIFT = 5'b00110; // SLL, SRA
	localparam logic [4:0] OPC_ADDIU3 = 5'b01000;
	localparam logic [4:0] OPC_ADDIU = 5'b01001;
	localparam logic [4:0] OPC_SP_GRP = 5'b01100; // ADDSP, BTEQZ, BTNEZ, MTSP, SW_RS
	localparam logic [4:0] OPC_LI = 5'b01101;
	localparam logic [4:0] OPC_CMPI = 5'b01110;
	localparam logic [4:0] OPC_LW_SP = 5'b10010;
	localparam logic [4:0] OPC_LW = 5'b10011;
	localparam logic [4:0] OPC_SW_SP = 5'b11010;
	localparam logic [4:0] OPC_SW = 5'b11011;
	localparam logic [4:0] OPC_RRR = 5'b11100; // ADDU, SUBU
	localparam logic [4:0] OPC_RR = 5'b11101; // Two-register ALU group and JR
	localparam logic [4:0] OPC_IH = 5'b11110; // MFIH, MTIH

	////////////////////////////////////////////////////////////
	// Sub-function fields
	////////////////////////////////////////////////////////////
	localparam logic [2:0] OPC_F_BTEQZ = 3'b000; // Bits 10:8
	localparam logic [2:0] OPC_F_BTNEZ = 3'b001;
	localparam logic [2:0] OPC_F_SW_RS = 3'b010;
	localparam logic [2:0] OPC_F_ADDSP = 3'b011;
	localparam logic [2:0] OPC_F_MTSP = 3'b100;
	localparam logic [1:0] OPC_F_ADDU = 2'b01; // Bits 1:0
	localparam logic [1:0] OPC_F_SUBU = 2'b11;
	localparam logic [1:0] OPC_F_SLL = 2'b00;
	localparam logic [1:0] OPC_F_SRA = 2'b11;
	localparam logic [4:0] OPC_F_JR_GRP = 5'b00000; // Bits 4:0
	localparam logic [4:0] OPC_F_SLT = 5'b00010;
	localparam logic [4:0] OPC_F_SRAV = 5'b00111;
	localparam logic [4:0] OPC_F_CMP = 5'b01010;
	localparam logic [4:0] OPC_F_AND = 5'b01100;
	localparam logic [4:0] OPC_F_OR = 5'b01101;
	localparam logic [2:0] OPC_F_JR = 3'b000; // Bits 7:5
	localparam logic [0:0] OPC_F_MFIH = 1'b0; // Bit 0
	localparam logic [0:0] OPC_F_MTIH = 1'b1;

	typedef enum logic [4:0] {
		KIND_NOP = 5'd0,
		KIND_ADDIU, KIND_ADDIU3, KIND_ADDSP, KIND_ADDU, KIND_SUBU,
		KIND_AND, KIND_OR, KIND_SLT, KIND_SRAV, KIND_SLL, KIND_SRA,
		KIND_CMP, KIND_CMPI, KIND_LI, KIND_MTSP, KIND_MFIH, KIND_MTIH,
		KIND_LW, KIND_LW_SP, KIND_SW, KIND_SW_SP, KIND_SW_RS,
		KIND_B, KIND_BEQZ, KIND_BNEZ, KIND_BTEQZ, KIND_BTNEZ, KIND_JR
	} instr_kind_t;

endpackage

// File: source/ctrl_pkg.sv
package ctrl_pkg;

	////////////////////////////////////////////////////////////
	// ALU operation
	////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_AND = 4'd1,
		ALU_OR = 4'd2,
		ALU_SLL = 4'd3,
		ALU_SRL = 4'd4, // Not produced by this decoder
		ALU_SRA = 4'd5,
		ALU_SUB = 4'd6,
		ALU_EQUAL = 4'd7, // Sets T on equality
		ALU_LESS = 4'd8, // Sets T on signed less-than
		ALU_MOVE = 4'd9, // Pass operand A
		ALU_NONE = 4'd15
	} alu_op_t;

	////////////////////////////////////////////////////////////
	// ALU operand selection
	////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		SRC_NONE = 3'd0,
		SRC_REG_REG = 3'd1, // A and B from the register file
		SRC_REG_IMM = 3'd2, // A from a register, B from imm
		SRC_REG_ONLY = 3'd3,
		SRC_IMM_ONLY = 3'd4
	} alu_src_t;

	// Condition tested on the register read through port A
	typedef enum logic [1:0] {
		COND_ALWAYS = 2'd0,
		COND_ZERO = 2'd1,
		COND_NONZERO = 2'd2
	} branch_cond_t;

endpackage

// File: source/instr_classifier.sv
`timescale 1ns/1ps

module instr_classifier (
	input isa_pkg::word_t instruction,
	output isa_pkg::instr_kind_t kind
);
	import isa_pkg::*;

	logic [4:0] opcode;

	assign opcode = instruction[15:11];

	////////////////////////////////////////////////////////////
	// Opcode and sub-field decode
	////////////////////////////////////////////////////////////
	always_comb begin
		kind = KIND_NOP; // Anything unmatched, INT and MFPC included
		case (opcode)
			OPC_NOP: kind = KIND_NOP;
			OPC_ADDIU: kind = KIND_ADDIU;
			OPC_ADDIU3: kind = KIND_ADDIU3;
			OPC_LI: kind = KIND_LI;
			OPC_CMPI: kind = KIND_CMPI;
			OPC_LW: kind = KIND_LW;
			OPC_LW_SP: kind = KIND_LW_SP;
			OPC_SW: kind = KIND_SW;
			OPC_SW_SP: kind = KIND_SW_SP;
			OPC_B: kind = KIND_B;
			OPC_BEQZ: kind = KIND_BEQZ;
			OPC_BNEZ: kind = KIND_BNEZ;
			OPC_SP_GRP: begin
				case (instruction[10:8])
					OPC_F_ADDSP: kind = KIND_ADDSP;
					OPC_F_BTEQZ: kind = KIND_BTEQZ;
					OPC_F_BTNEZ: kind = KIND_BTNEZ;
					OPC_F_MTSP: kind = KIND_MTSP;
					OPC_F_SW_RS: kind = KIND_SW_RS;
					default: kind = KIND_NOP;
				endcase
			end
			OPC_RRR: begin
				case (instruction[1:0])
					OPC_F_ADDU: kind = KIND_ADDU;
					OPC_F_SUBU: kind = KIND_SUBU;
					default: kind = KIND_NOP;
				endcase
			end
			OPC_RR: begin
				case (instruction[4:0])
					OPC_F_AND: kind = KIND_AND;
					OPC_F_OR: kind = KIND_OR;
					OPC_F_CMP: kind = KIND_CMP;
					OPC_F_SLT: kind = KIND_SLT;
					OPC_F_SRAV: kind = KIND_SRAV;
					OPC_F_JR_GRP: begin
						if (instruction[7:5] == OPC_F_JR) begin
							kind = KIND_JR;
						end
					end
					default: kind = KIND_NOP;
				endcase
			end
			OPC_SHIFT: begin
				case (instruction[1:0])
					OPC_F_SLL: kind = KIND_SLL;
					OPC_F_SRA: kind = KIND_SRA;
					default: kind = KIND_NOP;
				endcase
			end
			OPC_IH: begin
				case (instruction[0])
					OPC_F_MFIH: kind = KIND_MFIH;
					OPC_F_MTIH: kind = KIND_MTIH;
					default: kind = KIND_NOP;
				endcase
			end
			default: kind = KIND_NOP;
		endcase
	end

endmodule

// File: source/imm_extender.sv
`timescale 1ns/1ps

module imm_extender (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input isa_pkg::word_t instruction,
	input isa_pkg::instr_kind_t kind,
	output isa_pkg::word_t imm
);
	import isa_pkg::*;

	word_t imm_next;

	always_comb begin
		case (kind)
			KIND_ADDIU, KIND_ADDSP, KIND_CMPI,
			KIND_BEQZ, KIND_BNEZ, KIND_BTEQZ, KIND_BTNEZ,
			KIND_LW_SP, KIND_SW_SP, KIND_SW_RS: begin
				imm_next = {{8{instruction[7]}}, instruction[7:0]};
			end
			KIND_ADDIU3: imm_next = {{12{instruction[3]}}, instruction[3:0]};
			KIND_LW, KIND_SW: imm_next = {{11{instruction[4]}}, instruction[4:0]};
			KIND_B: imm_next = {{5{instruction[10]}}, instruction[10:0]}; // PC offset
			KIND_LI: imm_next = {8'h00, instruction[7:0]};
			KIND_SLL, KIND_SRA: begin
				if (instruction[4:2] == 3'b000) begin
					imm_next = 16'd8; // Encoded 0 shifts by 8
				end else begin
					imm_next = {13'd0, instruction[4:2]};
				end
			end
			default: imm_next = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			imm <= '0;
		end else if (instr_valid) begin
			imm <= imm_next;
		end
	end

endmodule

// File: source/reg_field_select.sv
`timescale 1ns/1ps

module reg_field_select (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input isa_pkg::word_t instruction,
	input isa_pkg::instr_kind_t kind,
	output isa_pkg::reg_addr_t rd_reg_a,
	output isa_pkg::reg_addr_t rd_reg_b,
	output isa_pkg::reg_addr_t fwd_src_a,
	output isa_pkg::reg_addr_t fwd_src_b,
	output isa_pkg::reg_addr_t fwd_src_store,
	output isa_pkg::reg_addr_t wr_reg
);
	import isa_pkg::*;

	reg_addr_t rx;
	reg_addr_t ry;
	reg_addr_t rz;
	reg_addr_t a_next;
	reg_addr_t b_next;
	reg_addr_t fa_next;
	reg_addr_t fb_next;
	reg_addr_t fs_next;
	reg_addr_t wr_next;

	assign rx = {1'b0, instruction[10:8]};
	assign ry = {1'b0, instruction[7:5]};
	assign rz = {1'b0, instruction[4:2]};

	// Read ports and forwarding sources
	always_comb begin
		a_next = REG_NONE;
		b_next = REG_NONE;
		fa_next = REG_NONE;
		fb_next = REG_NONE;
		fs_next = REG_NONE;
		case (kind)
			KIND_ADDIU, KIND_ADDIU3, KIND_LW, KIND_CMPI, KIND_MTIH: begin
				a_next = rx;
				fa_next = rx;
			end
			KIND_ADDSP, KIND_LW_SP: begin
				a_next = REG_SP;
				fa_next = REG_SP;
			end
			KIND_MFIH: begin
				a_next = REG_IH;
				fa_next = REG_IH;
			end
			KIND_MTSP, KIND_SLL, KIND_SRA: begin
				a_next = ry;
				fa_next = ry;
			end
			KIND_ADDU, KIND_SUBU, KIND_AND, KIND_OR, KIND_CMP, KIND_SLT: begin
				a_next = rx;
				b_next = ry;
				fa_next = rx;
				fb_next = ry;
			end
			KIND_SRAV: begin
				a_next = ry; // Value to shift
				b_next = rx; // Shift amount
				fa_next = ry;
				fb_next = rx;
			end
			KIND_SW: begin
				a_next = rx;
				b_next = ry;
				fa_next = rx;
				fs_next = ry;
			end
			KIND_SW_SP: begin
				a_next = REG_SP;
				b_next = rx;
				fa_next = REG_SP;
				fs_next = rx;
			end
			KIND_SW_RS: begin
				a_next = REG_SP;
				b_next = REG_RA;
				fa_next = REG_SP;
				fs_next = REG_RA;
			end
			KIND_BEQZ, KIND_BNEZ, KIND_JR: a_next = rx; // Resolved in ID, no forwarding
			KIND_BTEQZ, KIND_BTNEZ: a_next = REG_T;
			default: a_next = REG_NONE;
		endcase
	end

	// Write-back destination
	always_comb begin
		case (kind)
			KIND_ADDIU, KIND_AND, KIND_OR, KIND_LI,
			KIND_LW_SP, KIND_MFIH, KIND_SLL, KIND_SRA: wr_next = rx;
			KIND_ADDIU3, KIND_SRAV, KIND_LW: wr_next = ry;
			KIND_ADDU, KIND_SUBU: wr_next = rz;
			KIND_ADDSP, KIND_MTSP: wr_next = REG_SP;
			KIND_CMP, KIND_CMPI, KIND_SLT: wr_next = REG_T;
			KIND_MTIH: wr_next = REG_IH;
			default: wr_next = REG_NONE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_reg_a <= REG_NONE;
			rd_reg_b <= REG_NONE;
			fwd_src_a <= REG_NONE;
			fwd_src_b <= REG_NONE;
			fwd_src_store <= REG_NONE;
			wr_reg <= REG_NONE;
		end else if (instr_valid) begin
			rd_reg_a <= a_next;
			rd_reg_b <= b_next;
			fwd_src_a <= fa_next;
			fwd_src_b <= fb_next;
			fwd_src_store <= fs_next;
			wr_reg <= wr_next;
		end
	end

endmodule

// File: source/ctrl_gen.sv
`timescale 1ns/1ps

module ctrl_gen (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input isa_pkg::instr_kind_t kind,
	output logic decode_valid,
	output logic is_jump,
	output logic is_branch,
	output logic mem_read,
	output logic mem_write,
	output logic reg_write,
	output logic mem_to_reg,
	output ctrl_pkg::alu_op_t alu_op,
	output ctrl_pkg::alu_src_t alu_src,
	output ctrl_pkg::branch_cond_t branch_cond
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	alu_op_t op_next;
	alu_src_t src_next;
	branch_cond_t cond_next;
	logic jump_next;
	logic branch_next;
	logic read_next;
	logic write_next;
	logic reg_wr_next;
	logic to_reg_next;

	////////////////////////////////////////////////////////////
	// Control word per instruction kind
	////////////////////////////////////////////////////////////
	always_comb begin
		case (kind)
			KIND_ADDIU, KIND_ADDIU3, KIND_ADDSP, KIND_ADDU,
			KIND_LW, KIND_LW_SP, KIND_SW, KIND_SW_SP, KIND_SW_RS: op_next = ALU_ADD;
			KIND_SUBU: op_next = ALU_SUB;
			KIND_AND: op_next = ALU_AND;
			KIND_OR: op_next = ALU_OR;
			KIND_SLL: op_next = ALU_SLL;
			KIND_SRA, KIND_SRAV: op_next = ALU_SRA;
			KIND_CMP, KIND_CMPI: op_next = ALU_EQUAL;
			KIND_SLT: op_next = ALU_LESS;
			KIND_MTSP, KIND_MFIH, KIND_MTIH, KIND_LI: op_next = ALU_MOVE;
			default: op_next = ALU_NONE; // Branches, JR, NOP
		endcase
	end

	always_comb begin
		src_next = SRC_NONE;
		cond_next = COND_ALWAYS;
		jump_next = 1'b0;
		branch_next = 1'b0;
		read_next = 1'b0;
		write_next = 1'b0;
		reg_wr_next = 1'b0;
		to_reg_next = 1'b0;
		case (kind)
			KIND_ADDIU, KIND_ADDIU3, KIND_ADDSP, KIND_SLL, KIND_SRA, KIND_CMPI: begin
				src_next = SRC_REG_IMM;
				reg_wr_next = 1'b1;
			end
			KIND_ADDU, KIND_SUBU, KIND_AND, KIND_OR, KIND_CMP, KIND_SLT, KIND_SRAV: begin
				src_next = SRC_REG_REG;
				reg_wr_next = 1'b1;
			end
			KIND_MTSP, KIND_MFIH, KIND_MTIH: begin
				src_next = SRC_REG_ONLY;
				reg_wr_next = 1'b1;
			end
			KIND_LI: begin
				src_next = SRC_IMM_ONLY;
				reg_wr_next = 1'b1;
			end
			KIND_LW, KIND_LW_SP: begin
				src_next = SRC_REG_IMM; // Base plus offset
				read_next = 1'b1;
				reg_wr_next = 1'b1;
				to_reg_next = 1'b1;
			end
			KIND_SW, KIND_SW_SP, KIND_SW_RS: begin
				src_next = SRC_REG_IMM;
				write_next = 1'b1;
			end
			KIND_B: branch_next = 1'b1;
			KIND_BEQZ, KIND_BTEQZ: begin
				branch_next = 1'b1;
				cond_next = COND_ZERO;
			end
			KIND_BNEZ, KIND_BTNEZ: begin
				branch_next = 1'b1;
				cond_next = COND_NONZERO;
			end
			KIND_JR: jump_next = 1'b1;
			default: src_next = SRC_NONE;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Output registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			decode_valid <= 1'b0;
			is_jump <= 1'b0;
			is_branch <= 1'b0;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			reg_write <= 1'b0;
			mem_to_reg <= 1'b0;
			alu_op <= ALU_NONE;
			alu_src <= SRC_NONE;
			branch_cond <= COND_ALWAYS;
		end else begin
			decode_valid <= instr_valid;
			is_jump <= instr_valid & jump_next; // Pulses last one cycle
			is_branch <= instr_valid & branch_next;
			mem_read <= instr_valid & read_next;
			mem_write <= instr_valid & write_next;
			reg_write <= instr_valid & reg_wr_next;
			if (instr_valid) begin
				mem_to_reg <= to_reg_next;
				alu_op <= op_next;
				alu_src <= src_next;
				branch_cond <= cond_next;
			end
		end
	end

endmodule

// File: source/id_decoder.sv
`timescale 1ns/1ps

module id_decoder (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input isa_pkg::word_t instruction,
	output isa_pkg::reg_addr_t rd_reg_a,
	output isa_pkg::reg_addr_t rd_reg_b,
	output isa_pkg::reg_addr_t fwd_src_a,
	output isa_pkg::reg_addr_t fwd_src_b,
	output isa_pkg::reg_addr_t fwd_src_store,
	output isa_pkg::reg_addr_t wr_reg,
	output isa_pkg::word_t imm,
	output logic decode_valid,
	output logic is_jump,
	output logic is_branch,
	output logic mem_read,
	output logic mem_write,
	output logic reg_write,
	output logic mem_to_reg,
	output ctrl_pkg::alu_op_t alu_op,
	output ctrl_pkg::alu_src_t alu_src,
	output ctrl_pkg::branch_cond_t branch_cond
);
	import isa_pkg::*;

	instr_kind_t kind; // Shared by all three builders

	instr_classifier u_classifier (
		.instruction(instruction),
		.kind(kind)
	);

	imm_extender u_imm (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instruction(instruction),
		.kind(kind),
		.imm(imm)
	);

	reg_field_select u_regs (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instruction(instruction),
		.kind(kind),
		.rd_reg_a(rd_reg_a),
		.rd_reg_b(rd_reg_b),
		.fwd_src_a(fwd_src_a),
		.fwd_src_b(fwd_src_b),
		.fwd_src_store(fwd_src_store),
		.wr_reg(wr_reg)
	);

	ctrl_gen u_ctrl (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.kind(kind),
		.decode_valid(decode_valid),
		.is_jump(is_jump),
		.is_branch(is_branch),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.reg_write(reg_write),
		.mem_to_reg(mem_to_reg),
		.alu_op(alu_op),
		.alu_src(alu_src),
		.branch_cond(branch_cond)
	);

endmodule

// File: verification/id_decoder_chk.sv
`timescale 1ns/1ps

module id_decoder_chk (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input logic decode_valid,
	input logic is_jump,
	input logic is_branch,
	input logic mem_read,
	input logic mem_write,
	input logic mem_to_reg
);

	mem_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write are high together");

	flow_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(is_jump && is_branch))
		else $error("is_jump and is_branch are high together");

	load_to_reg: assert property (@(posedge clk) disable iff (rst)
		mem_read |-> mem_to_reg)
		else $error("mem_read without mem_to_reg");

	// Exactly one cycle of latency
	valid_follows: assert property (@(posedge clk) disable iff (rst)
		instr_valid |=> decode_valid)
		else $error("decode_valid missing one cycle after instr_valid");

	valid_needs_strobe: assert property (@(posedge clk) disable iff (rst)
		!instr_valid |=> !decode_valid)
		else $error("decode_valid high without a strobe one cycle earlier");

endmodule

bind id_decoder id_decoder_chk chk0 (
	.clk(clk),
	.rst(rst),
	.instr_valid(instr_valid),
	.decode_valid(decode_valid),
	.is_jump(is_jump),
	.is_branch(is_branch),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.mem_to_reg(mem_to_reg)
);

// File: verification/tb_id_decoder.sv
`timescale 1ns/1ps

module tb_id_decoder;
	import isa_pkg::*;
	import ctrl_pkg::*;

	localparam int NUM_VEC = 32;
	localparam int VEC_WORDS = 12; // Instruction plus eleven expected fields
	localparam int CYCLE_LIMIT = NUM_VEC * 5 + 20;
	localparam string STIM_FILE = "verification/decode_stim.txt";

	logic clk;
	logic rst;
	logic instr_valid;
	word_t instruction;
	reg_addr_t rd_reg_a;
	reg_addr_t rd_reg_b;
	reg_addr_t fwd_src_a;
	reg_addr_t fwd_src_b;
	reg_addr_t fwd_src_store;
	reg_addr_t wr_reg;
	word_t imm;
	logic decode_valid;
	logic is_jump;
	logic is_branch;
	logic mem_read;
	logic mem_write;
	logic reg_write;
	logic mem_to_reg;
	alu_op_t alu_op;
	alu_src_t alu_src;
	branch_cond_t branch_cond;

	logic [15:0] stim [NUM_VEC * VEC_WORDS];
	logic [15:0] held [VEC_WORDS]; // Expected value of each output, slot 0 unused
	int pending [$]; // Strobed vectors awaiting decode_valid
	int errors;
	int checks;
	int decoded;
	int cycle_count;
	int vec_idx;
	bit checker_on;
	logic strobe_seen; // Strobe taken at the last rising edge

	id_decoder dut0 (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instruction(instruction),
		.rd_reg_a(rd_reg_a),
		.rd_reg_b(rd_reg_b),
		.fwd_src_a(fwd_src_a),
		.fwd_src_b(fwd_src_b),
		.fwd_src_store(fwd_src_store),
		.wr_reg(wr_reg),
		.imm(imm),
		.decode_valid(decode_valid),
		.is_jump(is_jump),
		.is_branch(is_branch),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.reg_write(reg_write),
		.mem_to_reg(mem_to_reg),
		.alu_op(alu_op),
		.alu_src(alu_src),
		.branch_cond(branch_cond)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		strobe_seen <= instr_valid;
	end

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR: %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic compare_outputs(input bit pulse_cycle);
		logic [5:0] pulses;
		pulses = pulse_cycle ? held[11][5:0] : 6'd0; // Pulses drop in idle cycles
		check_value("rd_reg_a", held[1], rd_reg_a);
		check_value("rd_reg_b", held[2], rd_reg_b);
		check_value("fwd_src_a", held[3], fwd_src_a);
		check_value("fwd_src_b", held[4], fwd_src_b);
		check_value("fwd_src_store", held[5], fwd_src_store);
		check_value("wr_reg", held[6], wr_reg);
		check_value("imm", held[7], imm);
		check_value("alu_op", held[8], alu_op);
		check_value("alu_src", held[9], alu_src);
		check_value("branch_cond", held[10], branch_cond);
		check_value("is_jump", pulses[5], is_jump);
		check_value("is_branch", pulses[4], is_branch);
		check_value("mem_read", pulses[3], mem_read);
		check_value("mem_write", pulses[2], mem_write);
		check_value("reg_write", pulses[1], reg_write);
		check_value("mem_to_reg", held[11][0], mem_to_reg);
	endtask

	task automatic strobe_vector(input int idx);
		@(posedge clk);
		instr_valid <= 1'b1;
		instruction <= stim[idx * VEC_WORDS];
		pending.push_back(idx);
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			instruction <= word_t'($urandom); // Noise that must not reach the outputs
		end
	endtask

	////////////////////////////////////////////////////////////
	// Output checker, samples away from the active edge
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		if (checker_on && !rst) begin
			check_value("decode_valid", strobe_seen, decode_valid); // One cycle after the strobe
			if (decode_valid) begin
				if (pending.size() == 0) begin
					errors++;
					$display("decode_valid was raised with no instruction outstanding at %0t",
						$time);
				end else begin
					vec_idx = pending.pop_front();
					for (int f = 1; f < VEC_WORDS; f++) begin
						held[f] = stim[vec_idx * VEC_WORDS + f];
					end
					decoded++;
					compare_outputs(1'b1);
				end
			end else begin
				compare_outputs(1'b0);
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("The run timed out after %0d cycles without finishing", CYCLE_LIMIT);
		$display("Checks: %0d  errors: %0d", checks, errors + 1);
		$display("Test failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		instruction = '0;
		errors = 0;
		checks = 0;
		decoded = 0;
		checker_on = 1'b0;
		for (int f = 1; f <= 6; f++) begin
			held[f] = REG_NONE;
		end
		held[7] = '0;
		held[8] = ALU_NONE;
		held[9] = SRC_NONE;
		held[10] = COND_ALWAYS;
		held[11] = '0;
		void'($urandom(32'head3_2fff));
		$readmemh(STIM_FILE, stim);
		if ($isunknown(stim[NUM_VEC * VEC_WORDS - 1])) begin
			errors++;
			$display("The stimulus file %s is missing or holds fewer than %0d vectors",
				STIM_FILE, NUM_VEC);
		end else begin
			repeat (3) @(posedge clk);
			rst <= 1'b0;
			checker_on = 1'b1;
			idle_cycles(2); // Reset values with no strobe
			for (int i = 0; i < NUM_VEC; i++) begin
				strobe_vector(i); // Back to back
			end
			idle_cycles(2);
			for (int i = 0; i < NUM_VEC; i++) begin
				strobe_vector(i);
				idle_cycles($urandom % 4);
			end
			idle_cycles(2);
			while (pending.size() != 0) begin
				idle_cycles(1);
			end
			if (decoded != 2 * NUM_VEC) begin
				errors++;
				$display("Only %0d of %0d strobes produced a decode_valid cycle",
					decoded, 2 * NUM_VEC);
			end
		end
		$display("Checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: verification/decode_stim.txt
// instr rd_a rd_b fwd_a fwd_b fwd_st wr_reg imm alu_op alu_src cond ctrl
// ctrl bits 5..0: is_jump is_branch mem_read mem_write reg_write mem_to_reg
4a85 2 f 2 f f 2 ff85 0 2 0 02 // ADDIU
43ac 3 f 3 f f 5 fffc 0 2 0 02 // ADDIU3
6310 8 f 8 f f 8 0010 0 2 0 02 // ADDSP
e14d 1 2 1 2 f 3 0000 0 1 0 02 // ADDU
e4bb 4 5 4 5 f 6 0000 6 1 0 02 // SUBU
e8ec 0 7 0 7 f 0 0000 1 1 0 02 // AND
ee2d 6 1 6 1 f 6 0000 2 1 0 02 // OR
ea62 2 3 2 3 f 9 0000 8 1 0 02 // SLT
e987 4 1 4 1 f 4 0000 5 1 0 02 // SRAV
edca 5 6 5 6 f 9 0000 7 1 0 02 // CMP
3340 2 f 2 f f 3 0008 3 2 0 02 // SLL by 8
3737 1 f 1 f f 7 0005 5 2 0 02 // SRA
74fe 4 f 4 f f 9 fffe 7 2 0 02 // CMPI
699c f f f f f 1 009c 9 4 0 02 // LI
9a7f 2 f 2 f f 3 ffff 0 2 0 0b // LW
9540 8 f 8 f f 5 0040 0 2 0 0b // LW_SP
deea 6 7 6 f 7 f 000a 0 2 0 04 // SW
d3f0 8 3 8 f 3 f fff0 0 2 0 04 // SW_SP
6208 8 b 8 f b f 0008 0 2 0 04 // SW_RS
6440 2 f 2 f f 8 0000 9 3 0 02 // MTSP
f400 a f a f f 4 0000 9 3 0 02 // MFIH
f301 3 f 3 f f a 0000 9 3 0 02 // MTIH
17f0 f f f f f f fff0 f 0 0 10 // B
2212 2 f f f f f 0012 f 0 1 10 // BEQZ
2f80 7 f f f f f ff80 f 0 2 10 // BNEZ
6005 9 f f f f f 0005 f 0 1 10 // BTEQZ
61fb 9 f f f f f fffb f 0 2 10 // BTNEZ
ed00 5 f f f f f 0000 f 0 0 20 // JR
0800 f f f f f f 0000 f 0 0 00 // NOP
eb40 f f f f f f 0000 f 0 0 00 // MFPC as NOP
f80a f f f f f f 0000 f 0 0 00 // INT as NOP
07ff f f f f f f 0000 f 0 0 00 // Undefined opcode

// File: files.f
source/isa_pkg.sv
source/ctrl_pkg.sv
source/instr_classifier.sv
source/imm_extender.sv
source/reg_field_select.sv
source/ctrl_gen.sv
source/id_decoder.sv
verification/id_decoder_chk.sv
verification/tb_id_decoder.sv
